// File: hw/dispatch_pkg.sv
package dispatch_pkg;

    // machine sizes
    localparam int ROB_PAIRS = 16;
    localparam int PRF_NUM   = 64;

    // pointer width inside the allocator
    localparam int ROB_PTR_W = $clog2(ROB_PAIRS);

    // physical register number
    typedef logic [$clog2(PRF_NUM)-1:0] prf_num_t;

    // rob entry id is pair index with the slot bit below it
    typedef logic [7:0] rob_id_t;
    typedef logic [6:0] rob_pair_t;

    // allocator pointer and occupancy
    typedef logic [ROB_PTR_W-1:0] rob_ptr_t;
    typedef logic [ROB_PTR_W:0]   rob_count_t;

    typedef logic [5:0] uop_code_t;

    // no real work
    localparam uop_code_t NOP_U      = 6'h00;
    localparam uop_code_t MDBUBBLE_U = 6'h01;

    // plain alu and load examples
    localparam uop_code_t ADD_U      = 6'h02;
    localparam uop_code_t LW_U       = 6'h10;

    // stores
    localparam uop_code_t SB_U       = 6'h18;
    localparam uop_code_t SH_U       = 6'h19;
    localparam uop_code_t SW_U       = 6'h1a;
    localparam uop_code_t SWL_U      = 6'h1b;
    localparam uop_code_t SWR_U      = 6'h1c;

    // multiplies, hi and lo halves
    localparam uop_code_t MULTHI_U   = 6'h20;
    localparam uop_code_t MULTLO_U   = 6'h21;
    localparam uop_code_t MULTUHI_U  = 6'h22;
    localparam uop_code_t MULTULO_U  = 6'h23;

    // divide goes to the mdu too
    localparam uop_code_t DIV_U      = 6'h24;

    // target issue queue
    typedef enum logic [1:0] {
        RS_ALU = 2'd0,
        RS_MDU = 2'd1,
        RS_LSU = 2'd2
    } rs_type_e;

endpackage

// File: hw/dispatch.sv
`timescale 1ns/1ns

module dispatch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inst0_valid_i,
    input  logic                    inst1_valid_i,
    input  dispatch_pkg::uop_code_t inst0_uop_i,
    input  dispatch_pkg::uop_code_t inst1_uop_i,
    input  dispatch_pkg::rs_type_e  inst0_rs_type_i,
    input  dispatch_pkg::rs_type_e  inst1_rs_type_i,
    input  logic                    inst0_priv_i,
    input  logic                    inst1_priv_i,
    input  dispatch_pkg::prf_num_t  inst0_dst_i,
    input  dispatch_pkg::prf_num_t  inst1_dst_i,
    input  logic                    inst0_dstwe_i,
    input  logic                    inst1_dstwe_i,
    input  logic                    rob_ready_i,
    input  logic                    rob_empty_i,
    input  dispatch_pkg::rob_pair_t rob_tail_i,
    output logic                    pause_o,
    output logic                    alloc_o,
    output logic                    alu_wen0_o,
    output logic                    alu_wen1_o,
    output dispatch_pkg::uop_code_t alu_uop0_o,
    output dispatch_pkg::uop_code_t alu_uop1_o,
    output dispatch_pkg::rob_id_t   alu_id0_o,
    output dispatch_pkg::rob_id_t   alu_id1_o,
    output dispatch_pkg::prf_num_t  alu_dst0_o,
    output dispatch_pkg::prf_num_t  alu_dst1_o,
    output logic                    mdu_wen_o,
    output dispatch_pkg::uop_code_t mdu_uop_o,
    output dispatch_pkg::rob_id_t   mdu_id_o,
    output dispatch_pkg::prf_num_t  mdu_dst_o,
    output logic                    mdu_is_mul_o,
    output logic                    lsu_wen0_o,
    output logic                    lsu_wen1_o,
    output dispatch_pkg::uop_code_t lsu_uop0_o,
    output dispatch_pkg::uop_code_t lsu_uop1_o,
    output dispatch_pkg::rob_id_t   lsu_id0_o,
    output dispatch_pkg::rob_id_t   lsu_id1_o,
    output dispatch_pkg::prf_num_t  lsu_dst0_o,
    output dispatch_pkg::prf_num_t  lsu_dst1_o,
    output logic                    lsu_is_store0_o,
    output logic                    lsu_is_store1_o,
    output logic                    set0_o,
    output logic                    set1_o,
    output dispatch_pkg::prf_num_t  set_num0_o,
    output dispatch_pkg::prf_num_t  set_num1_o
);
    import dispatch_pkg::*;

    // privileged op serialization
    typedef enum logic [2:0] {
        IDLE,
        WAIT0,
        WR0,
        WAIT1,
        WR1
    } state_e;

    state_e    state_q;
    state_e    state_d;
    logic      has_priv;

    // output lane 0, carries lane 1's op during WR1
    logic      lane0_valid;
    logic      lane1_valid;
    logic      lane0_from_inst1;
    uop_code_t lane0_uop;
    rs_type_e  lane0_rs_type;
    prf_num_t  lane0_dst;
    logic      lane0_dstwe;
    rob_id_t   id0;
    rob_id_t   id1;

    logic      alu0;
    logic      alu1;
    logic      lsu0;
    logic      lsu1;

    function automatic logic is_store(input uop_code_t uop);
        return (uop == SB_U) || (uop == SH_U) || (uop == SW_U) ||
               (uop == SWL_U) || (uop == SWR_U);
    endfunction

    function automatic logic is_mul(input uop_code_t uop);
        return (uop == MULTHI_U) || (uop == MULTLO_U) ||
               (uop == MULTUHI_U) || (uop == MULTULO_U);
    endfunction

    function automatic logic does_work(input uop_code_t uop);
        return (uop != NOP_U) && (uop != MDBUBBLE_U);
    endfunction

    assign has_priv = (inst0_valid_i && inst0_priv_i) || (inst1_valid_i && inst1_priv_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (has_priv) begin
                    state_d = WAIT0;
                end
            end
            WAIT0: begin
                if (rob_empty_i) begin
                    state_d = WR0;
                end
            end
            WR0: begin
                state_d = inst1_valid_i ? WAIT1 : IDLE;
            end
            WAIT1: begin
                if (rob_empty_i) begin
                    state_d = WR1;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // the last write of a serialized pair returns to IDLE, which releases rename
    assign pause_o = !rob_ready_i || (state_d != IDLE);

    always_comb begin
        lane0_valid = 1'b0;
        lane1_valid = 1'b0;
        case (state_q)
            IDLE: begin
                lane0_valid = inst0_valid_i && !pause_o;
                lane1_valid = inst1_valid_i && !pause_o;
            end
            WR0: begin
                lane0_valid = inst0_valid_i;
            end
            WR1: begin
                lane0_valid = inst1_valid_i;
            end
            default: begin
                lane0_valid = 1'b0;
                lane1_valid = 1'b0;
            end
        endcase
    end

    assign lane0_from_inst1 = (state_q == WR1);
    assign lane0_uop     = lane0_from_inst1 ? inst1_uop_i     : inst0_uop_i;
    assign lane0_rs_type = lane0_from_inst1 ? inst1_rs_type_i : inst0_rs_type_i;
    assign lane0_dst     = lane0_from_inst1 ? inst1_dst_i     : inst0_dst_i;
    assign lane0_dstwe   = lane0_from_inst1 ? inst1_dstwe_i   : inst0_dstwe_i;

    // both lanes share the tail pair
    assign id0 = {rob_tail_i, 1'b0};
    assign id1 = {rob_tail_i, 1'b1};

    assign alloc_o = lane0_valid || lane1_valid;

    assign alu0 = lane0_valid && (lane0_rs_type == RS_ALU);
    assign alu1 = lane1_valid && (inst1_rs_type_i == RS_ALU);
    assign lsu0 = lane0_valid && (lane0_rs_type == RS_LSU);
    assign lsu1 = lane1_valid && (inst1_rs_type_i == RS_LSU);

    // alu slots packed from 0
    assign alu_wen0_o = alu0 || alu1;
    assign alu_wen1_o = alu0 && alu1;
    assign alu_uop0_o = alu0 ? lane0_uop : inst1_uop_i;
    assign alu_id0_o  = alu0 ? id0 : id1;
    assign alu_dst0_o = alu0 ? lane0_dst : inst1_dst_i;
    assign alu_uop1_o = inst1_uop_i;
    assign alu_id1_o  = id1;
    assign alu_dst1_o = inst1_dst_i;

    // mdu only takes lane 0
    assign mdu_wen_o    = lane0_valid && (lane0_rs_type == RS_MDU);
    assign mdu_uop_o    = lane0_uop;
    assign mdu_id_o     = id0;
    assign mdu_dst_o    = lane0_dst;
    assign mdu_is_mul_o = is_mul(lane0_uop);

    // lsu slots packed like the alu
    assign lsu_wen0_o      = lsu0 || lsu1;
    assign lsu_wen1_o      = lsu0 && lsu1;
    assign lsu_uop0_o      = lsu0 ? lane0_uop : inst1_uop_i;
    assign lsu_id0_o       = lsu0 ? id0 : id1;
    assign lsu_dst0_o      = lsu0 ? lane0_dst : inst1_dst_i;
    assign lsu_is_store0_o = lsu0 ? is_store(lane0_uop) : is_store(inst1_uop_i);
    assign lsu_uop1_o      = inst1_uop_i;
    assign lsu_id1_o       = id1;
    assign lsu_dst1_o      = inst1_dst_i;
    assign lsu_is_store1_o = is_store(inst1_uop_i);

    // busy set, each lane on its own valid
    assign set0_o     = lane0_valid && lane0_dstwe && does_work(lane0_uop);
    assign set1_o     = lane1_valid && inst1_dstwe_i && does_work(inst1_uop_i);
    assign set_num0_o = lane0_dst;
    assign set_num1_o = inst1_dst_i;

endmodule

// File: hw/rob_alloc.sv
`timescale 1ns/1ns

module rob_alloc (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    alloc_i,
    input  logic                    commit_i,
    output dispatch_pkg::rob_pair_t tail_o,
    output logic                    ready_o,
    output logic                    empty_o
);
    import dispatch_pkg::*;

    rob_ptr_t   head_q;
    rob_ptr_t   tail_q;
    rob_count_t count_q;
    logic       full;
    logic       do_alloc;
    logic       do_commit;

    assign full = (count_q == rob_count_t'(ROB_PAIRS));

    // equal pointers mean empty unless the count says full
    assign empty_o = (head_q == tail_q) && !full;
    assign ready_o = !full;
    assign tail_o  = rob_pair_t'(tail_q);

    // commit on an empty rob is dropped
    assign do_alloc  = alloc_i && !full;
    assign do_commit = commit_i && !empty_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            // ROB_PAIRS is a power of two so pointers wrap on overflow
            if (do_alloc) begin
                tail_q <= tail_q + 1'b1;
            end
            if (do_commit) begin
                head_q <= head_q + 1'b1;
            end
            if (do_alloc && !do_commit) begin
                count_q <= count_q + 1'b1;
            end else if (do_commit && !do_alloc) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// File: hw/busy_table.sv
`timescale 1ns/1ns

module busy_table (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   set0_i,
    input  logic                   set1_i,
    input  dispatch_pkg::prf_num_t set_num0_i,
    input  dispatch_pkg::prf_num_t set_num1_i,
    input  logic                   wb_i,
    input  dispatch_pkg::prf_num_t wb_num_i,
    input  dispatch_pkg::prf_num_t rd_num_i,
    output logic                   busy_o
);
    import dispatch_pkg::*;

    logic [PRF_NUM-1:0] busy_q;
    logic [PRF_NUM-1:0] busy_d;

    always_comb begin
        busy_d = busy_q;
        for (int i = 0; i < PRF_NUM; i++) begin
            if (wb_i && (wb_num_i == prf_num_t'(i))) begin
                busy_d[i] = 1'b0;
            end
            // set after clear, so a dispatch beats a same-cycle writeback
            if ((set0_i && (set_num0_i == prf_num_t'(i))) ||
                (set1_i && (set_num1_i == prf_num_t'(i)))) begin
                busy_d[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

    // combinational read port
    assign busy_o = busy_q[rd_num_i];

endmodule

// File: hw/dispatch_top.sv
`timescale 1ns/1ns

module dispatch_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inst0_valid_i,
    input  logic                    inst1_valid_i,
    input  dispatch_pkg::uop_code_t inst0_uop_i,
    input  dispatch_pkg::uop_code_t inst1_uop_i,
    input  dispatch_pkg::rs_type_e  inst0_rs_type_i,
    input  dispatch_pkg::rs_type_e  inst1_rs_type_i,
    input  logic                    inst0_priv_i,
    input  logic                    inst1_priv_i,
    input  dispatch_pkg::prf_num_t  inst0_dst_i,
    input  dispatch_pkg::prf_num_t  inst1_dst_i,
    input  logic                    inst0_dstwe_i,
    input  logic                    inst1_dstwe_i,
    input  logic                    commit_i,
    input  logic                    wb_i,
    input  dispatch_pkg::prf_num_t  wb_num_i,
    input  dispatch_pkg::prf_num_t  rd_num_i,
    output logic                    pause_o,
    output logic                    alu_wen0_o,
    output logic                    alu_wen1_o,
    output dispatch_pkg::uop_code_t alu_uop0_o,
    output dispatch_pkg::uop_code_t alu_uop1_o,
    output dispatch_pkg::rob_id_t   alu_id0_o,
    output dispatch_pkg::rob_id_t   alu_id1_o,
    output dispatch_pkg::prf_num_t  alu_dst0_o,
    output dispatch_pkg::prf_num_t  alu_dst1_o,
    output logic                    mdu_wen_o,
    output dispatch_pkg::uop_code_t mdu_uop_o,
    output dispatch_pkg::rob_id_t   mdu_id_o,
    output dispatch_pkg::prf_num_t  mdu_dst_o,
    output logic                    mdu_is_mul_o,
    output logic                    lsu_wen0_o,
    output logic                    lsu_wen1_o,
    output dispatch_pkg::uop_code_t lsu_uop0_o,
    output dispatch_pkg::uop_code_t lsu_uop1_o,
    output dispatch_pkg::rob_id_t   lsu_id0_o,
    output dispatch_pkg::rob_id_t   lsu_id1_o,
    output dispatch_pkg::prf_num_t  lsu_dst0_o,
    output dispatch_pkg::prf_num_t  lsu_dst1_o,
    output logic                    lsu_is_store0_o,
    output logic                    lsu_is_store1_o,
    output logic                    busy_o
);
    import dispatch_pkg::*;

    // dispatch to allocator
    logic      alloc;
    logic      rob_ready;
    logic      rob_empty;
    rob_pair_t rob_tail;

    // dispatch to scoreboard
    logic      set0;
    logic      set1;
    prf_num_t  set_num0;
    prf_num_t  set_num1;

    dispatch u_dispatch (
        .clk             (clk),
        .rst             (rst),
        .inst0_valid_i   (inst0_valid_i),
        .inst1_valid_i   (inst1_valid_i),
        .inst0_uop_i     (inst0_uop_i),
        .inst1_uop_i     (inst1_uop_i),
        .inst0_rs_type_i (inst0_rs_type_i),
        .inst1_rs_type_i (inst1_rs_type_i),
        .inst0_priv_i    (inst0_priv_i),
        .inst1_priv_i    (inst1_priv_i),
        .inst0_dst_i     (inst0_dst_i),
        .inst1_dst_i     (inst1_dst_i),
        .inst0_dstwe_i   (inst0_dstwe_i),
        .inst1_dstwe_i   (inst1_dstwe_i),
        .rob_ready_i     (rob_ready),
        .rob_empty_i     (rob_empty),
        .rob_tail_i      (rob_tail),
        .pause_o         (pause_o),
        .alloc_o         (alloc),
        .alu_wen0_o      (alu_wen0_o),
        .alu_wen1_o      (alu_wen1_o),
        .alu_uop0_o      (alu_uop0_o),
        .alu_uop1_o      (alu_uop1_o),
        .alu_id0_o       (alu_id0_o),
        .alu_id1_o       (alu_id1_o),
        .alu_dst0_o      (alu_dst0_o),
        .alu_dst1_o      (alu_dst1_o),
        .mdu_wen_o       (mdu_wen_o),
        .mdu_uop_o       (mdu_uop_o),
        .mdu_id_o        (mdu_id_o),
        .mdu_dst_o       (mdu_dst_o),
        .mdu_is_mul_o    (mdu_is_mul_o),
        .lsu_wen0_o      (lsu_wen0_o),
        .lsu_wen1_o      (lsu_wen1_o),
        .lsu_uop0_o      (lsu_uop0_o),
        .lsu_uop1_o      (lsu_uop1_o),
        .lsu_id0_o       (lsu_id0_o),
        .lsu_id1_o       (lsu_id1_o),
        .lsu_dst0_o      (lsu_dst0_o),
        .lsu_dst1_o      (lsu_dst1_o),
        .lsu_is_store0_o (lsu_is_store0_o),
        .lsu_is_store1_o (lsu_is_store1_o),
        .set0_o          (set0),
        .set1_o          (set1),
        .set_num0_o      (set_num0),
        .set_num1_o      (set_num1)
    );

    rob_alloc u_rob_alloc (
        .clk      (clk),
        .rst      (rst),
        .alloc_i  (alloc),
        .commit_i (commit_i),
        .tail_o   (rob_tail),
        .ready_o  (rob_ready),
        .empty_o  (rob_empty)
    );

    busy_table u_busy_table (
        .clk        (clk),
        .rst        (rst),
        .set0_i     (set0),
        .set1_i     (set1),
        .set_num0_i (set_num0),
        .set_num1_i (set_num1),
        .wb_i       (wb_i),
        .wb_num_i   (wb_num_i),
        .rd_num_i   (rd_num_i),
        .busy_o     (busy_o)
    );

endmodule

// File: test/dispatch_assert.sv
`timescale 1ns/1ns

module dispatch_assert (
    input logic       clk,
    input logic       rst,
    input logic       pause_i,
    input logic [2:0] state_i,
    input logic       rob_empty_i,
    input logic       rob_ready_i,
    input logic       alu_wen0_i,
    input logic       alu_wen1_i,
    input logic       mdu_wen_i,
    input logic       lsu_wen0_i,
    input logic       lsu_wen1_i
);
    logic any_wen;

    assign any_wen = alu_wen0_i || alu_wen1_i || mdu_wen_i || lsu_wen0_i || lsu_wen1_i;

    // slots fill from 0 upward
    alu_pack_a: assert property (@(posedge clk) disable iff (rst) alu_wen1_i |-> alu_wen0_i)
        else $error("alu slot 1 written without slot 0");
    lsu_pack_a: assert property (@(posedge clk) disable iff (rst) lsu_wen1_i |-> lsu_wen0_i)
        else $error("lsu slot 1 written without slot 0");

    // state encoding 0 is IDLE
    pause_idle_a: assert property (@(posedge clk) disable iff (rst)
        (pause_i && (state_i == 3'd0)) |-> !any_wen)
        else $error("queue written while paused in IDLE");

    reset_quiet_a: assert property (@(posedge clk) $fell(rst) |-> !any_wen)
        else $error("queue written in the first cycle after reset");

    rob_state_a: assert property (@(posedge clk) disable iff (rst) !(rob_empty_i && !rob_ready_i))
        else $error("allocator reports empty and full together");

endmodule

bind dispatch_top dispatch_assert u_dispatch_assert (
    .clk         (clk),
    .rst         (rst),
    .pause_i     (pause_o),
    .state_i     (u_dispatch.state_q),
    .rob_empty_i (rob_empty),
    .rob_ready_i (rob_ready),
    .alu_wen0_i  (alu_wen0_o),
    .alu_wen1_i  (alu_wen1_o),
    .mdu_wen_i   (mdu_wen_o),
    .lsu_wen0_i  (lsu_wen0_o),
    .lsu_wen1_i  (lsu_wen1_o)
);

// File: test/dispatch_tb.sv
`timescale 1ns/1ns

module dispatch_tb;
    import dispatch_pkg::*;

    localparam int TEST_CYCLES = 700;
    localparam int S_IDLE = 0;
    localparam int S_WAIT0 = 1;
    localparam int S_WR0 = 2;
    localparam int S_WAIT1 = 3;
    localparam int S_WR1 = 4;

    logic clk = 1'b0;
    logic rst;
    logic inst0_valid_i, inst1_valid_i, inst0_priv_i, inst1_priv_i;
    logic inst0_dstwe_i, inst1_dstwe_i, commit_i, wb_i;
    uop_code_t inst0_uop_i, inst1_uop_i;
    rs_type_e inst0_rs_type_i, inst1_rs_type_i;
    prf_num_t inst0_dst_i, inst1_dst_i, wb_num_i, rd_num_i;
    logic pause_o, alu_wen0_o, alu_wen1_o, mdu_wen_o, mdu_is_mul_o, busy_o;
    logic lsu_wen0_o, lsu_wen1_o, lsu_is_store0_o, lsu_is_store1_o;
    uop_code_t alu_uop0_o, alu_uop1_o, mdu_uop_o, lsu_uop0_o, lsu_uop1_o;
    rob_id_t alu_id0_o, alu_id1_o, mdu_id_o, lsu_id0_o, lsu_id1_o;
    prf_num_t alu_dst0_o, alu_dst1_o, mdu_dst_o, lsu_dst0_o, lsu_dst1_o;

    // reference model state
    int m_state, m_count, m_tail;
    logic [PRF_NUM-1:0] m_busy;
    logic exp_pause;
    logic [110:0] exp_vec, act_vec;
    logic e_alloc, e_s0, e_s1, e_busy;
    prf_num_t e_n0, e_n1;
    logic [31:0] lfsr_q = 32'hf2ed;
    string test_name;
    int test_errs, total_errs, tests_failed;

    uop_code_t alu_codes[2] = '{ADD_U, NOP_U};
    uop_code_t mdu_codes[6] = '{MULTHI_U, MULTLO_U, MULTUHI_U, MULTULO_U, DIV_U, MDBUBBLE_U};
    uop_code_t lsu_codes[6] = '{LW_U, SB_U, SH_U, SW_U, SWL_U, SWR_U};

    dispatch_top DUT (.*);

    always #10 clk = ~clk;

    function automatic logic next_bit();
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
        return lfsr_q[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [21:0] slot(input logic wen, input uop_code_t uop,
                                         input rob_id_t id, input prf_num_t dst,
                                         input logic flag);
        return wen ? {1'b1, uop, id, dst, flag} : 22'd0;
    endfunction

    function automatic int next_state(input int st, input int cnt);
        logic priv;
        priv = (inst0_valid_i && inst0_priv_i) || (inst1_valid_i && inst1_priv_i);
        case (st)
            S_IDLE: return priv ? S_WAIT0 : S_IDLE;
            S_WAIT0: return (cnt == 0) ? S_WR0 : S_WAIT0;
            S_WR0: return inst1_valid_i ? S_WAIT1 : S_IDLE;
            S_WAIT1: return (cnt == 0) ? S_WR1 : S_WAIT1;
            default: return S_IDLE;
        endcase
    endfunction

    // expected queue slots and pause from the inputs and the model rob
    function automatic logic [110:0] ref_out(input int st, input int cnt,
                                             input logic [6:0] tail,
                                             output logic alloc,
                                             output logic set0, output prf_num_t num0,
                                             output logic set1, output prf_num_t num1);
        logic pause;
        logic lv[2];
        uop_code_t lu[2];
        rs_type_e lr[2];
        prf_num_t ld[2];
        logic lw[2];
        logic [21:0] alu_s[2];
        logic [21:0] lsu_s[2];
        logic [21:0] mdu_s;
        int na;
        int nl;
        pause = (cnt == ROB_PAIRS) || (next_state(st, cnt) != S_IDLE);
        lv[0] = 1'b0;
        lv[1] = 1'b0;
        lu[0] = inst0_uop_i;
        lr[0] = inst0_rs_type_i;
        ld[0] = inst0_dst_i;
        lw[0] = inst0_dstwe_i;
        lu[1] = inst1_uop_i;
        lr[1] = inst1_rs_type_i;
        ld[1] = inst1_dst_i;
        lw[1] = inst1_dstwe_i;
        if (st == S_IDLE && !pause) begin
            lv[0] = inst0_valid_i;
            lv[1] = inst1_valid_i;
        end else if (st == S_WR0) begin
            lv[0] = inst0_valid_i;
        end else if (st == S_WR1) begin
            // lane 1's op goes out alone on lane 0
            lv[0] = inst1_valid_i;
            lu[0] = inst1_uop_i;
            lr[0] = inst1_rs_type_i;
            ld[0] = inst1_dst_i;
            lw[0] = inst1_dstwe_i;
        end
        na = 0;
        nl = 0;
        alu_s[0] = '0;
        alu_s[1] = '0;
        lsu_s[0] = '0;
        lsu_s[1] = '0;
        mdu_s = '0;
        for (int k = 0; k < 2; k++) begin
            if (lv[k] && lr[k] == RS_ALU) begin
                alu_s[na] = slot(1'b1, lu[k], {tail, k == 1}, ld[k], 1'b0);
                na++;
            end
            if (lv[k] && lr[k] == RS_LSU) begin
                lsu_s[nl] = slot(1'b1, lu[k], {tail, k == 1}, ld[k],
                                 lu[k] inside {SB_U, SH_U, SW_U, SWL_U, SWR_U});
                nl++;
            end
        end
        if (lv[0] && lr[0] == RS_MDU) begin
            mdu_s = slot(1'b1, lu[0], {tail, 1'b0}, ld[0],
                         lu[0] inside {MULTHI_U, MULTLO_U, MULTUHI_U, MULTULO_U});
        end
        alloc = lv[0] || lv[1];
        set0 = lv[0] && lw[0] && !(lu[0] inside {NOP_U, MDBUBBLE_U});
        set1 = lv[1] && lw[1] && !(lu[1] inside {NOP_U, MDBUBBLE_U});
        num0 = ld[0];
        num1 = ld[1];
        return {pause, alu_s[0], alu_s[1], mdu_s, lsu_s[0], lsu_s[1]};
    endfunction

    // compare in the middle of the cycle, then advance the model
    always @(negedge clk) begin
        if (rst) begin
            m_state = S_IDLE;
            m_count = 0;
            m_tail = 0;
            m_busy = '0;
            exp_pause = 1'b0;
        end else begin
            exp_vec = ref_out(m_state, m_count, 7'(m_tail), e_alloc, e_s0, e_n0, e_s1, e_n1);
            act_vec = {pause_o,
                       slot(alu_wen0_o, alu_uop0_o, alu_id0_o, alu_dst0_o, 1'b0),
                       slot(alu_wen1_o, alu_uop1_o, alu_id1_o, alu_dst1_o, 1'b0),
                       slot(mdu_wen_o, mdu_uop_o, mdu_id_o, mdu_dst_o, mdu_is_mul_o),
                       slot(lsu_wen0_o, lsu_uop0_o, lsu_id0_o, lsu_dst0_o, lsu_is_store0_o),
                       slot(lsu_wen1_o, lsu_uop1_o, lsu_id1_o, lsu_dst1_o, lsu_is_store1_o)};
            assert (act_vec == exp_vec) else begin
                $display("[FAIL] %s outputs: expected %h, actual %h", test_name, exp_vec, act_vec);
                test_errs++;
            end
            e_busy = m_busy[rd_num_i];
            assert (busy_o == e_busy) else begin
                $display("[FAIL] %s busy[%0d]: expected %b, actual %b",
                         test_name, rd_num_i, e_busy, busy_o);
                test_errs++;
            end
            exp_pause = exp_vec[110];
            m_state = next_state(m_state, m_count);
            if (wb_i) m_busy[wb_num_i] = 1'b0;
            if (e_s0) m_busy[e_n0] = 1'b1;
            if (e_s1) m_busy[e_n1] = 1'b1;
            m_count = m_count + (e_alloc ? 1 : 0) - ((commit_i && m_count > 0) ? 1 : 0);
            if (e_alloc) m_tail = (m_tail + 1) % ROB_PAIRS;
        end
    end

    task automatic apply(input logic v0, input uop_code_t u0, input rs_type_e r0,
                         input logic p0, input prf_num_t d0, input logic w0,
                         input logic v1, input uop_code_t u1, input rs_type_e r1,
                         input logic p1, input prf_num_t d1, input logic w1);
        @(posedge clk);
        inst0_valid_i <= v0;
        inst0_uop_i <= u0;
        inst0_rs_type_i <= r0;
        inst0_priv_i <= p0;
        inst0_dst_i <= d0;
        inst0_dstwe_i <= w0;
        inst1_valid_i <= v1;
        inst1_uop_i <= u1;
        inst1_rs_type_i <= r1;
        inst1_priv_i <= p1;
        inst1_dst_i <= d1;
        inst1_dstwe_i <= w1;
    endtask

    // rename holds the pair until pause drops
    task automatic wait_accept();
        do begin
            @(negedge clk);
            #1;
        end while (exp_pause);
    endtask

    task automatic go_idle();
        apply(1'b0, NOP_U, RS_ALU, 1'b0, '0, 1'b0, 1'b0, NOP_U, RS_ALU, 1'b0, '0, 1'b0);
    endtask

    task automatic drive_commit(input logic c);
        @(posedge clk);
        commit_i <= c;
    endtask

    task automatic drain_rob();
        go_idle();
        commit_i <= 1'b1;
        do begin
            @(negedge clk);
            #1;
        end while (m_count != 0);
    endtask

    task automatic send_random_pair();
        rs_type_e r[2];
        uop_code_t u[2];
        for (int k = 0; k < 2; k++) begin
            r[k] = rs_type_e'(rand_bits(2) % 3);
            u[k] = (r[k] == RS_ALU) ? alu_codes[rand_bits(1)] :
                   (r[k] == RS_MDU) ? mdu_codes[rand_bits(3) % 6] : lsu_codes[rand_bits(3) % 6];
        end
        apply(rand_bits(1) == 1, u[0], r[0], 1'b0, prf_num_t'(rand_bits(6)), rand_bits(1) == 1,
              rand_bits(1) == 1, u[1], r[1], 1'b0, prf_num_t'(rand_bits(6)), rand_bits(1) == 1);
        wb_i <= rand_bits(1) == 1;
        wb_num_i <= prf_num_t'(rand_bits(6));
        rd_num_i <= prf_num_t'(rand_bits(6));
        wait_accept();
    endtask

    task automatic send_alu_pair(input prf_num_t d0, input prf_num_t d1);
        apply(1'b1, ADD_U, RS_ALU, 1'b0, d0, 1'b1, 1'b1, ADD_U, RS_ALU, 1'b0, d1, 1'b1);
    endtask

    task automatic end_test();
        $display("test %s: %s, %0d errors", test_name, test_errs == 0 ? "ok" : "failed",
                 test_errs);
        total_errs += test_errs;
        if (test_errs != 0) tests_failed++;
        test_errs = 0;
    endtask

    initial begin
        #(TEST_CYCLES * 20 * 2);
        $display("watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rst = 1'b1;
        {inst0_valid_i, inst1_valid_i, inst0_priv_i, inst1_priv_i} = '0;
        {inst0_dstwe_i, inst1_dstwe_i, commit_i, wb_i} = '0;
        {inst0_uop_i, inst1_uop_i} = {NOP_U, NOP_U};
        inst0_rs_type_i = RS_ALU;
        inst1_rs_type_i = RS_ALU;
        {inst0_dst_i, inst1_dst_i, wb_num_i, rd_num_i} = '0;
        test_name = "reset";
        test_errs = 0;
        total_errs = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        go_idle();
        end_test();

        test_name = "routing";
        commit_i <= 1'b1;
        repeat (150) send_random_pair();
        go_idle();
        wb_i <= 1'b0;
        end_test();

        test_name = "rob_ids";
        drain_rob();
        for (int i = 0; i < 20; i++) send_alu_pair(prf_num_t'(i), prf_num_t'(i + 32));
        end_test();

        test_name = "back_pressure";
        drain_rob();
        drive_commit(1'b0);
        for (int i = 0; i < 16; i++) begin
            send_alu_pair(prf_num_t'(i), prf_num_t'(i + 16));
            wait_accept();
        end
        send_alu_pair(6'd40, 6'd41);
        repeat (4) @(negedge clk);
        drive_commit(1'b1);
        wait_accept();
        end_test();

        test_name = "serialize";
        drain_rob();
        drive_commit(1'b0);
        repeat (3) begin
            send_alu_pair(6'd1, 6'd2);
            wait_accept();
        end
        apply(1'b1, ADD_U, RS_ALU, 1'b1, 6'd20, 1'b1, 1'b1, LW_U, RS_LSU, 1'b0, 6'd21, 1'b1);
        repeat (5) @(negedge clk);
        drive_commit(1'b1);
        wait_accept();
        end_test();

        test_name = "busy_table";
        drain_rob();
        // start from clear registers
        for (int i = 10; i < 13; i++) begin
            go_idle();
            wb_i <= 1'b1;
            wb_num_i <= prf_num_t'(i);
        end
        apply(1'b1, ADD_U, RS_ALU, 1'b0, 6'd10, 1'b1, 1'b1, NOP_U, RS_ALU, 1'b0, 6'd11, 1'b1);
        wb_i <= 1'b0;
        rd_num_i <= 6'd10;
        go_idle();
        apply(1'b1, MDBUBBLE_U, RS_MDU, 1'b0, 6'd11, 1'b1, 1'b0, NOP_U, RS_ALU, 1'b0, '0, 1'b0);
        wb_i <= 1'b1;
        wb_num_i <= 6'd10;
        rd_num_i <= 6'd11;
        apply(1'b1, ADD_U, RS_ALU, 1'b0, 6'd12, 1'b1, 1'b0, NOP_U, RS_ALU, 1'b0, '0, 1'b0);
        wb_num_i <= 6'd12;
        rd_num_i <= 6'd10;
        go_idle();
        wb_i <= 1'b0;
        rd_num_i <= 6'd12;
        go_idle();
        rd_num_i <= 6'd11;
        go_idle();
        @(negedge clk);
        #1;
        end_test();

        $display("tests run: 6, tests failed: %0d, errors: %0d", tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: dispatch_top.f
hw/dispatch_pkg.sv
hw/dispatch.sv
hw/rob_alloc.sv
hw/busy_table.sv
hw/dispatch_top.sv
test/dispatch_assert.sv
test/dispatch_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the dispatch testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dispatch_top.f --top-module dispatch_tb \
    -o dispatch_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/dispatch_sim > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0
